/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := icache_tb
FILELIST  := all.f

BUILD   := obj_dir
SIM     := $(BUILD)/V$(TOP)
LOG     := sim.log
SOURCES := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
+incdir+verilog
verilog/icache_pkg.sv
verilog/fill_bus_pkg.sv
verilog/icache_ifs.sv
verilog/icache_store.sv
verilog/icache_lookup.sv
verilog/icache_refill.sv
verilog/icache_readout.sv
verilog/icache_top.sv
sim/tb_clock_gen.sv
sim/tb_fill_memory.sv
sim/icache_tb.sv

/* sim/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb
   import icache_pkg::*, fill_bus_pkg::*;
();
   typedef struct {
      word_addr_t addr;
      logic       hit;
      int         reqs;
      logic       rst;
   } entry_t;

   localparam int     N_ENTRIES  = 14;
   localparam int     MAX_CYCLES = N_ENTRIES * 20;
   localparam tag_t   TAG_A      = 11'h055;
   localparam tag_t   TAG_B      = 11'h2C1;
   localparam index_t IDX_X      = 4'h3;
   localparam index_t IDX_Y      = 4'hA;

   logic       clk;
   logic       rst;
   logic       fetch;
   word_addr_t addr;
   logic       busy;
   instr_t     instr;
   logic       instr_valid;
   logic       fill_req;
   beat_addr_t fill_addr;
   beat_t      fill_data;
   logic       fill_valid;
   int         served;
   int         served_before;
   int         cycles = 0;
   int         i;
   logic       chained;
   entry_t     tbl [N_ENTRIES];
   beat_addr_t req_log [$];

   tb_clock_gen #(.PERIOD(8)) clock_gen (.clk_o(clk));

   icache_top uut (
      .clk_i         (clk),
      .rst_i         (rst),
      .fetch_i       (fetch),
      .addr_i        (addr),
      .busy_o        (busy),
      .instr_o       (instr),
      .instr_valid_o (instr_valid),
      .fill_req_o    (fill_req),
      .fill_addr_o   (fill_addr),
      .fill_data_i   (fill_data),
      .fill_valid_i  (fill_valid)
   );

   tb_fill_memory fill_mem (
      .clk_i    (clk),
      .rst_i    (rst),
      .req_i    (fill_req),
      .addr_i   (fill_addr),
      .data_o   (fill_data),
      .valid_o  (fill_valid),
      .served_o (served)
   );

   always @(negedge clk) begin
      if (fill_req && fill_valid) begin
         req_log.push_back(fill_addr); // Address of every beat handed over.
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("ERROR: the cache did not finish the test table within %0d cycles",
                  MAX_CYCLES);
         $display("=== FAIL ===");
         $fatal(1, "timeout");
      end
   end

   function automatic word_addr_t make_addr(tag_t tag, index_t index, word_sel_t word);
      return {tag, index, word};
   endfunction

   function automatic instr_t expected_word(word_addr_t a);
      return {14'h2A5, a}; // Memory word rule.
   endfunction

   function automatic beat_addr_t expected_beat(word_addr_t a, beat_sel_t b);
      return {a[$bits(word_addr_t)-1:$bits(word_sel_t)], b};
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("=== FAIL ===");
         $fatal(1, "check failed");
      end
   endtask

   task automatic load_table();
      tbl[0]  = '{make_addr(TAG_A, IDX_X, 3'd5), 1'b0, 2, 1'b0}; // Cold miss.
      tbl[1]  = '{make_addr(TAG_A, IDX_X, 3'd0), 1'b1, 0, 1'b0};
      tbl[2]  = '{make_addr(TAG_A, IDX_X, 3'd7), 1'b1, 0, 1'b0};
      tbl[3]  = '{make_addr(TAG_A, IDX_X, 3'd2), 1'b1, 0, 1'b0};
      tbl[4]  = '{make_addr(TAG_A, IDX_X, 3'd4), 1'b1, 0, 1'b0};
      tbl[5]  = '{make_addr(TAG_B, IDX_X, 3'd1), 1'b0, 2, 1'b0}; // Evicts line A.
      tbl[6]  = '{make_addr(TAG_B, IDX_X, 3'd6), 1'b1, 0, 1'b0};
      tbl[7]  = '{make_addr(TAG_A, IDX_X, 3'd5), 1'b0, 2, 1'b0};
      tbl[8]  = '{make_addr(TAG_A, IDX_Y, 3'd3), 1'b0, 2, 1'b0};
      tbl[9]  = '{make_addr(TAG_A, IDX_X, 3'd1), 1'b1, 0, 1'b0};
      tbl[10] = '{make_addr(TAG_A, IDX_Y, 3'd7), 1'b1, 0, 1'b0};
      tbl[11] = '{make_addr(TAG_A, IDX_X, 3'd5), 1'b0, 2, 1'b1}; // Reset first.
      tbl[12] = '{make_addr(TAG_A, IDX_X, 3'd3), 1'b1, 0, 1'b0};
      tbl[13] = '{make_addr(TAG_A, IDX_Y, 3'd0), 1'b0, 2, 1'b0};
   endtask

   task automatic apply_reset();
      rst <= 1'b1;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_value(32'(busy), 32'(0), "busy after reset");
      check_value(32'(fill_req), 32'(0), "fill request after reset");
      check_value(32'(instr_valid), 32'(0), "instr_valid after reset");
      @(posedge clk);
   endtask

   task automatic strobe_entry(input int k);
      served_before = served;
      req_log.delete();
      fetch <= 1'b1;
      addr  <= tbl[k].addr;
   endtask

   task automatic check_hit(input int k);
      check_value(32'(instr_valid), 32'(1), "instr_valid one cycle after hit");
      check_value(instr, expected_word(tbl[k].addr), "hit word");
      check_value(32'(busy), 32'(0), "busy on hit");
      check_value(32'(fill_req), 32'(0), "fill request on hit");
   endtask

   task automatic check_miss(input int k);
      check_value(32'(busy), 32'(1), "busy after miss");
      check_value(32'(instr_valid), 32'(0), "instr_valid during miss");
      check_value(32'(fill_req), 32'(1), "fill request after miss");
      while (instr_valid !== 1'b1) begin
         @(negedge clk);
      end
      check_value(instr, expected_word(tbl[k].addr), "refilled word");
      check_value(32'(busy), 32'(0), "busy falls with instr_valid");
      check_value(served - served_before, tbl[k].reqs, "requests served on miss");
      check_value(32'(req_log.size()), tbl[k].reqs, "beats logged on miss");
      for (int b = 0; b < req_log.size(); b++) begin
         check_value(32'(req_log[b]), 32'(expected_beat(tbl[k].addr, beat_sel_t'(b))),
                     "beat address");
      end
   endtask

   initial begin
      rst     = 1'b1;
      fetch   = 1'b0;
      addr    = '0;
      chained = 1'b0;
      load_table();
      apply_reset();
      i = 0;
      while (i < N_ENTRIES) begin
         if (!chained) begin
            if (tbl[i].rst) begin
               apply_reset();
            end
            strobe_entry(i);
         end
         @(posedge clk);
         // Hits in a row are strobed on consecutive cycles.
         chained = (i + 1 < N_ENTRIES) && tbl[i].hit && tbl[i + 1].hit && !tbl[i + 1].rst;
         if (chained) begin
            strobe_entry(i + 1);
         end else begin
            fetch <= 1'b0;
         end
         @(negedge clk);
         if (tbl[i].hit) begin
            check_hit(i);
         end else begin
            check_miss(i);
         end
         if (!chained) begin
            @(posedge clk);
         end
         i++;
      end
      $display("=== PASS ===");
      $finish;
   end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD = 8
)(
   output logic clk_o
);
   logic clk = 1'b0;

   always #(PERIOD / 2) clk = ~clk; // Free running from time zero.

   assign clk_o = clk;

endmodule

/* sim/tb_fill_memory.sv */
`timescale 1ns/1ns

module tb_fill_memory
   import fill_bus_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       req_i,
   input  beat_addr_t addr_i,
   output beat_t      data_o,
   output logic       valid_o,
   output int         served_o
);
   localparam int WORDS = $bits(beat_t) / 32;

   logic       valid_q = 1'b0;
   beat_t      data_q = '0;
   int         served_q = 0;
   logic       pending = 1'b0;
   int         wait_cnt = 0;
   beat_addr_t addr_q = '0;
   integer     seed = 4;

   // Each word holds a fixed pattern over its own word address.
   function automatic beat_t beat_data(beat_addr_t a);
      beat_t d;
      for (int w = 0; w < WORDS; w++) begin
         d[w*32 +: 32] = {14'h2A5, a, 2'(w)};
      end
      return d;
   endfunction

   always @(posedge clk_i) begin
      if (rst_i) begin
         valid_q  <= 1'b0;
         pending  <= 1'b0;
         served_q <= 0;
      end else begin
         valid_q <= 1'b0;
         if (pending) begin
            if (wait_cnt <= 1) begin
               valid_q  <= 1'b1;
               data_q   <= beat_data(addr_q);
               pending  <= 1'b0;
               served_q <= served_q + 1;
            end else begin
               wait_cnt <= wait_cnt - 1;
            end
         end else if (req_i && !valid_q) begin
            pending  <= 1'b1;
            addr_q   <= addr_i;
            wait_cnt <= 1 + ({$random(seed)} % 4); // 1 to 4 cycles.
         end
      end
   end

   assign data_o   = data_q;
   assign valid_o  = valid_q;
   assign served_o = served_q;

endmodule

/* verilog/fill_bus_pkg.sv */
`include "icache_params.svh"

package fill_bus_pkg;

   // One beat carries half a line.
   typedef logic [32*`ICACHE_WORDS_PER_LINE/`ICACHE_BEATS_PER_LINE-1:0] beat_t;

   typedef logic [$clog2(`ICACHE_BEATS_PER_LINE)-1:0] beat_sel_t;

   // Tag, index and beat number of the beat being fetched.
   typedef logic [`ICACHE_TAG_W+`ICACHE_INDEX_W+$bits(beat_sel_t)-1:0] beat_addr_t;

endpackage

/* verilog/icache_ifs.sv */
`timescale 1ns/1ns

interface miss_if
   import icache_pkg::*;
();
   logic      miss;
   tag_t      tag;
   index_t    index;
   word_sel_t word_sel;

   modport master (output miss, tag, index, word_sel);
   modport slave (input miss, tag, index, word_sel);
endinterface

interface line_write_if
   import icache_pkg::*, fill_bus_pkg::*;
();
   logic      beat_we;
   logic      tag_we;
   index_t    index;
   beat_sel_t beat_sel;
   beat_t     beat;
   tag_t      tag;
   logic      replay;
   word_sel_t word_sel;

   modport master (output beat_we, tag_we, index, beat_sel, beat, tag, replay, word_sel);
   modport lookup (input tag_we, index, tag, replay);
   modport readout (input beat_we, index, beat_sel, beat, replay, word_sel);
endinterface

/* verilog/icache_lookup.sv */
`timescale 1ns/1ns

`include "icache_params.svh"

module icache_lookup
   import icache_pkg::*;
(
   input  logic          clk_i,
   input  logic          rst_i,
   input  logic          fetch_i,
   input  word_addr_t    addr_i,
   output logic          busy_o,
   miss_if.master        miss,
   line_write_if.lookup  wr,
   output logic          hit_o,
   output index_t        hit_index_o,
   output word_sel_t     hit_word_o
);
   localparam int WORD_W  = $bits(word_sel_t);
   localparam int INDEX_W = `ICACHE_INDEX_W;
   localparam int TAG_LSB = WORD_W + INDEX_W;
   localparam int LINES   = 1 << INDEX_W;

   tag_t       tag;
   index_t     index;
   word_sel_t  word;
   tag_entry_t entry;
   tag_entry_t new_entry;
   logic       hit;
   logic       accept;
   logic       busy_q;

   assign tag   = addr_i[TAG_LSB +: `ICACHE_TAG_W];
   assign index = addr_i[WORD_W +: INDEX_W];
   assign word  = addr_i[WORD_W-1:0];

   assign new_entry.valid = 1'b1;
   assign new_entry.tag   = wr.tag;

   icache_store #(
      .DEPTH   (LINES),
      .entry_t (tag_entry_t)
   ) tag_store (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .we_i    (wr.tag_we),
      .waddr_i (wr.index),
      .raddr_i (index),
      .wdata_i (new_entry),
      .rdata_o (entry)
   );

   assign hit    = entry.valid && (entry.tag == tag);
   assign accept = fetch_i && !busy_q; // Strobes during a refill are dropped.

   assign hit_o       = accept && hit;
   assign hit_index_o = index;
   assign hit_word_o  = word;

   assign miss.miss     = accept && !hit;
   assign miss.tag      = tag;
   assign miss.index    = index;
   assign miss.word_sel = word;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_q <= 1'b0;
      end else if (miss.miss) begin
         busy_q <= 1'b1;
      end else if (wr.replay) begin
         busy_q <= 1'b0; // Falls with instr_valid_o.
      end
   end

   assign busy_o = busy_q;

endmodule

/* verilog/icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Byte address width of the fetch port and the refill bus.
`define ICACHE_ADDR_W 20

// 16 direct-mapped lines.
`define ICACHE_INDEX_W 4

// 32-byte line of 32-bit words.
`define ICACHE_WORDS_PER_LINE 8

// A line arrives as two 128-bit beats.
`define ICACHE_BEATS_PER_LINE 2

// Address width minus 5 offset bits minus the index bits.
`define ICACHE_TAG_W 11

`endif

/* verilog/icache_pkg.sv */
`include "icache_params.svh"

package icache_pkg;

   // Word address, byte offset bits dropped.
   typedef logic [`ICACHE_ADDR_W-3:0] word_addr_t;

   typedef logic [`ICACHE_TAG_W-1:0] tag_t;

   typedef logic [`ICACHE_INDEX_W-1:0] index_t;

   typedef logic [$clog2(`ICACHE_WORDS_PER_LINE)-1:0] word_sel_t;

   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   typedef logic [31:0] instr_t;

endpackage

/* verilog/icache_readout.sv */
`timescale 1ns/1ns

`include "icache_params.svh"

module icache_readout
   import icache_pkg::*, fill_bus_pkg::*;
(
   input  logic          clk_i,
   input  logic          rst_i,
   input  logic          hit_i,
   input  index_t        hit_index_i,
   input  word_sel_t     hit_word_i,
   line_write_if.readout wr,
   output instr_t        instr_o,
   output logic          instr_valid_o
);
   localparam int DEPTH  = (1 << `ICACHE_INDEX_W) * `ICACHE_BEATS_PER_LINE;
   localparam int SEL_W  = $bits(word_sel_t);
   localparam int BEAT_W = $bits(beat_sel_t);
   localparam int LOW_W  = SEL_W - BEAT_W;
   localparam int INSTR_W = $bits(instr_t);

   index_t           rd_index;
   word_sel_t        rd_word;
   beat_sel_t        rd_beat;
   logic [LOW_W-1:0] rd_low;
   beat_t            rd_data;
   instr_t           word;
   logic             load;

   assign load     = hit_i || wr.replay;
   assign rd_index = wr.replay ? wr.index : hit_index_i;
   assign rd_word  = wr.replay ? wr.word_sel : hit_word_i;
   assign rd_beat  = rd_word[SEL_W-1 -: BEAT_W]; // Upper word bits pick the beat.
   assign rd_low   = rd_word[LOW_W-1:0];

   icache_store #(
      .DEPTH   (DEPTH),
      .entry_t (beat_t)
   ) data_store (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .we_i    (wr.beat_we),
      .waddr_i ({wr.index, wr.beat_sel}),
      .raddr_i ({rd_index, rd_beat}),
      .wdata_i (wr.beat),
      .rdata_o (rd_data)
   );

   assign word = rd_data[rd_low * INSTR_W +: INSTR_W];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         instr_valid_o <= 1'b0;
      end else begin
         instr_valid_o <= load;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         instr_o <= word;
      end
   end

endmodule

/* verilog/icache_refill.sv */
`timescale 1ns/1ns

`include "icache_params.svh"

module icache_refill
   import icache_pkg::*, fill_bus_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_i,
   miss_if.slave        miss,
   line_write_if.master wr,
   output logic         fill_req_o,
   output beat_addr_t   fill_addr_o,
   input  beat_t        fill_data_i,
   input  logic         fill_valid_i
);
   localparam beat_sel_t LAST_BEAT = beat_sel_t'(`ICACHE_BEATS_PER_LINE - 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_DROP,
      ST_FINISH
   } state_t;

   state_t    state;
   beat_sel_t beat_cnt;
   tag_t      tag_q;
   index_t    index_q;
   word_sel_t word_q;
   logic      last_beat;

   assign last_beat = (beat_cnt == LAST_BEAT);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state    <= ST_IDLE;
         beat_cnt <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (miss.miss) begin
                  state    <= ST_REQ;
                  beat_cnt <= '0;
               end
            end
            ST_REQ: begin
               if (fill_valid_i) begin
                  state <= ST_DROP; // Request low for one cycle.
               end
            end
            ST_DROP: begin
               if (last_beat) begin
                  state <= ST_FINISH;
               end else begin
                  state    <= ST_REQ;
                  beat_cnt <= beat_cnt + 1'b1;
               end
            end
            default: state <= ST_IDLE; // Replay cycle.
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state == ST_IDLE && miss.miss) begin
         tag_q   <= miss.tag;
         index_q <= miss.index;
         word_q  <= miss.word_sel;
      end
   end

   assign fill_req_o  = (state == ST_REQ);
   assign fill_addr_o = {tag_q, index_q, beat_cnt};

   assign wr.beat_we  = (state == ST_REQ) && fill_valid_i;
   assign wr.beat     = fill_data_i;
   assign wr.beat_sel = beat_cnt;
   assign wr.index    = index_q;
   assign wr.tag      = tag_q;
   assign wr.tag_we   = (state == ST_DROP) && last_beat; // Whole line is in.
   assign wr.replay   = (state == ST_FINISH);
   assign wr.word_sel = word_q;

endmodule

/* verilog/icache_store.sv */
`timescale 1ns/1ns

module icache_store
   import icache_pkg::*;
#(
   parameter int  DEPTH   = 16,
   parameter type entry_t = tag_entry_t
)(
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     we_i,
   input  logic [$clog2(DEPTH)-1:0] waddr_i,
   input  logic [$clog2(DEPTH)-1:0] raddr_i,
   input  entry_t                   wdata_i,
   output entry_t                   rdata_o
);
   entry_t mem [DEPTH];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0; // All lines invalid.
         end
      end else if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   assign rdata_o = mem[raddr_i]; // Read through, same cycle.

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/1ns

module icache_top
   import icache_pkg::*, fill_bus_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       fetch_i,
   input  word_addr_t addr_i,
   output logic       busy_o,
   output instr_t     instr_o,
   output logic       instr_valid_o,
   output logic       fill_req_o,
   output beat_addr_t fill_addr_o,
   input  beat_t      fill_data_i,
   input  logic       fill_valid_i
);
   logic      hit;
   index_t    hit_index;
   word_sel_t hit_word;

   miss_if       miss_bus ();
   line_write_if wr_bus ();

   icache_lookup u_lookup (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .fetch_i     (fetch_i),
      .addr_i      (addr_i),
      .busy_o      (busy_o),
      .miss        (miss_bus.master),
      .wr          (wr_bus.lookup),
      .hit_o       (hit),
      .hit_index_o (hit_index),
      .hit_word_o  (hit_word)
   );

   icache_refill u_refill (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .miss         (miss_bus.slave),
      .wr           (wr_bus.master),
      .fill_req_o   (fill_req_o),
      .fill_addr_o  (fill_addr_o),
      .fill_data_i  (fill_data_i),
      .fill_valid_i (fill_valid_i)
   );

   icache_readout u_readout (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .hit_i         (hit),
      .hit_index_i   (hit_index),
      .hit_word_i    (hit_word),
      .wr            (wr_bus.readout),
      .instr_o       (instr_o),
      .instr_valid_o (instr_valid_o)
   );

endmodule
